// File: filelist.f
logic/loader_pkg.sv
logic/loader_ifs.sv
logic/access_request_port.sv
logic/position_page_converter.sv
logic/spi_flash_reader.sv
logic/loop_map_table.sv
logic/load_sequencer.sv
logic/buffer_writer.sv
logic/bubble_loader_top.sv
tb/flash_model.sv
tb/bubble_loader_properties.sv
tb/tb_bubble_loader.sv

// File: logic/access_request_port.sv
`timescale 1ns/1ns

module access_request_port
(
    input  logic                         MCLK,
    input  logic                         reset,
    input  logic                         access_req,
    input  logic                         access_page,
    input  logic [loader_pkg::pos_w-1:0] abs_pos,
    output logic                         start,
    output logic                         page_mode,
    output logic [loader_pkg::pos_w-1:0] position,
    input  logic                         finished,
    output logic                         access_ack
);

    logic busy;     // accepted, sequencer still working

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            start      <= 1'b0;
            busy       <= 1'b0;
            access_ack <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            if (access_req && !busy && !access_ack)
            begin
                start <= 1'b1;
                busy  <= 1'b1;
            end
            else if (busy && finished)
            begin
                busy       <= 1'b0;
                access_ack <= 1'b1;     // held until the emulator lets go
            end
            else if (access_ack && !access_req)
                access_ack <= 1'b0;
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (access_req && !busy && !access_ack)
        begin
            page_mode <= access_page;
            position  <= abs_pos;
        end
    end

endmodule

// File: logic/bubble_loader_top.sv
`timescale 1ns/1ns

module bubble_loader_top
#(
    parameter int PAGE_COUNT = 2053,
    parameter int BOOT_BITS  = 2656,
    parameter int MAP_BITS   = 1200,
    parameter int HEAD_BITS  = 6,
    parameter int PAGE_BITS  = 1024
)
(
    input  logic                               MCLK,
    input  logic                               reset,
    input  logic [2:0]                         image_sel,
    input  logic                               access_req,
    input  logic                               access_page,
    input  logic [loader_pkg::pos_w-1:0]       abs_pos,
    output logic                               access_ack,
    output logic [loader_pkg::pos_w-1:0]       curr_page,
    output logic                               out_wr_en,
    output logic [loader_pkg::out_addr_w-1:0]  out_wr_addr,
    output logic                               out_wr_data,
    output logic                               fifo_wr_en,
    output logic [loader_pkg::fifo_addr_w-1:0] fifo_wr_addr,
    output logic                               fifo_wr_data,
    output logic                               flash_cs_n,
    output logic                               flash_sck,
    output logic                               flash_mosi,
    input  logic                               flash_miso
);

    import loader_pkg::*;

    logic             start;
    logic             page_mode;
    logic             finished;
    logic             convert;
    logic             conv_done;
    logic [pos_w-1:0] position;     // latched request position

    flash_read_if   fr_if ();
    buffer_write_if bw_if ();
    loop_map_if     lm_if ();

    access_request_port u_port
    (
        .MCLK        (MCLK),
        .reset       (reset),
        .access_req  (access_req),
        .access_page (access_page),
        .abs_pos     (abs_pos),
        .start       (start),
        .page_mode   (page_mode),
        .position    (position),
        .finished    (finished),
        .access_ack  (access_ack)
    );

    position_page_converter #(.PAGE_COUNT(PAGE_COUNT)) u_conv
    (
        .MCLK     (MCLK),
        .reset    (reset),
        .convert  (convert),
        .position (position),
        .page     (curr_page),
        .done     (conv_done)
    );

    load_sequencer
    #(
        .BOOT_BITS (BOOT_BITS),
        .MAP_BITS  (MAP_BITS),
        .HEAD_BITS (HEAD_BITS),
        .PAGE_BITS (PAGE_BITS)
    ) u_seq
    (
        .MCLK      (MCLK),
        .reset     (reset),
        .start     (start),
        .page_mode (page_mode),
        .image_sel (image_sel),
        .page      (curr_page),
        .convert   (convert),
        .conv_done (conv_done),
        .finished  (finished),
        .fr        (fr_if.master),
        .bw        (bw_if.master),
        .lm        (lm_if.master)
    );

    spi_flash_reader u_flash
    (
        .MCLK       (MCLK),
        .reset      (reset),
        .fr         (fr_if.slave),
        .flash_cs_n (flash_cs_n),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

    loop_map_table u_map
    (
        .MCLK  (MCLK),
        .reset (reset),
        .lm    (lm_if.slave)
    );

    buffer_writer u_wr
    (
        .MCLK         (MCLK),
        .reset        (reset),
        .bw           (bw_if.slave),
        .out_wr_en    (out_wr_en),
        .out_wr_addr  (out_wr_addr),
        .out_wr_data  (out_wr_data),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_addr (fifo_wr_addr),
        .fifo_wr_data (fifo_wr_data)
    );

endmodule

// File: logic/buffer_writer.sv
`timescale 1ns/1ns

module buffer_writer
(
    input  logic                               MCLK,
    input  logic                               reset,
    buffer_write_if.slave                      bw,
    output logic                               out_wr_en,
    output logic [loader_pkg::out_addr_w-1:0]  out_wr_addr,
    output logic                               out_wr_data,
    output logic                               fifo_wr_en,
    output logic [loader_pkg::fifo_addr_w-1:0] fifo_wr_addr,
    output logic                               fifo_wr_data
);

    import loader_pkg::*;

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            out_wr_en    <= 1'b0;
            fifo_wr_en   <= 1'b0;
            out_wr_addr  <= '0;
            fifo_wr_addr <= '0;
            bw.wr_ack    <= 1'b0;
        end
        else
        begin
            if (bw.region_start)
            begin
                out_wr_addr  <= bw.region_page ? page_data_base : '0;
                fifo_wr_addr <= '0;
            end
            if (out_wr_en)
            begin
                out_wr_en   <= 1'b0;
                fifo_wr_en  <= 1'b0;
                out_wr_addr <= out_wr_addr + 1'b1;
                if (fifo_wr_en)
                    fifo_wr_addr <= fifo_wr_addr + 1'b1;   // skipped loops leave no gap
                bw.wr_ack <= 1'b1;
            end
            else if (bw.wr_req && !bw.wr_ack)
            begin
                out_wr_en  <= 1'b1;
                fifo_wr_en <= bw.fifo_copy;
            end
            else if (!bw.wr_req)
                bw.wr_ack <= 1'b0;
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (bw.wr_req && !bw.wr_ack && !out_wr_en)
        begin
            out_wr_data  <= bw.wr_data;
            fifo_wr_data <= bw.wr_data;
        end
    end

endmodule

// File: logic/load_sequencer.sv
`timescale 1ns/1ns

module load_sequencer
#(
    parameter int BOOT_BITS = 2656,
    parameter int MAP_BITS  = 1200,
    parameter int HEAD_BITS = 6,
    parameter int PAGE_BITS = 1024
)
(
    input  logic                         MCLK,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         page_mode,
    input  logic [2:0]                   image_sel,
    input  logic [loader_pkg::pos_w-1:0] page,
    output logic                         convert,
    input  logic                         conv_done,
    output logic                         finished,
    flash_read_if.master                 fr,
    buffer_write_if.master               bw,
    loop_map_if.master                   lm
);

    import loader_pkg::*;

    typedef enum logic [3:0]
    {
        st_idle,
        st_conv,
        st_addr,
        st_cmd,
        st_fetch,
        st_write,
        st_map_rd,
        st_map_wait,
        st_done
    } state_t;

    typedef enum logic [1:0] {ph_boot, ph_map, ph_head, ph_data} phase_t;

    state_t      state;
    phase_t      phase;
    logic [11:0] loop_cnt;      // written bits, or good loops in a page
    logic [11:0] loop_last;
    logic        good;          // current write counts toward the phase
    logic        phase_end;

    always_comb
    begin
        case (phase)
            ph_boot: loop_last = 12'(BOOT_BITS - 1);
            ph_map:  loop_last = 12'(MAP_BITS - 1);
            ph_head: loop_last = 12'(HEAD_BITS - 1);
            default: loop_last = 12'(PAGE_BITS - 1);
        endcase
    end

    assign phase_end = good && (loop_cnt == loop_last);
    assign lm.rd     = (state == st_map_rd);

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            state           <= st_idle;
            phase           <= ph_boot;
            convert         <= 1'b0;
            finished        <= 1'b0;
            fr.session      <= 1'b0;
            fr.bit_req      <= 1'b0;
            bw.region_start <= 1'b0;
            bw.wr_req       <= 1'b0;
            lm.clear        <= 1'b0;
            lm.wr           <= 1'b0;
        end
        else
        begin
            convert         <= 1'b0;
            finished        <= 1'b0;
            bw.region_start <= 1'b0;
            lm.clear        <= 1'b0;
            lm.wr           <= 1'b0;
            case (state)
                st_idle:
                    if (start)
                    begin
                        lm.clear        <= 1'b1;
                        bw.region_start <= 1'b1;
                        bw.region_page  <= page_mode;
                        convert         <= page_mode;
                        phase           <= page_mode ? ph_head : ph_boot;
                        loop_cnt        <= '0;
                        state           <= page_mode ? st_conv : st_addr;
                    end
                st_conv:
                    if (conv_done)
                        state <= st_addr;
                st_addr:
                begin
                    fr.flash_addr <= {2'b00, image_sel, page_mode ? page : boot_page, 7'd0};
                    fr.session    <= 1'b1;
                    state         <= st_cmd;
                end
                st_cmd:
                    if (fr.cmd_done)
                        state <= page_mode ? st_map_rd : st_fetch;
                st_fetch:
                    if (!fr.bit_req && !fr.bit_ack)
                        fr.bit_req <= 1'b1;
                    else if (fr.bit_req && fr.bit_ack)
                    begin
                        fr.bit_req   <= 1'b0;
                        bw.wr_data   <= fr.bit_data;
                        bw.fifo_copy <= 1'b1;
                        lm.wr        <= (phase == ph_map);  // map bits also fill the table
                        lm.wr_bit    <= fr.bit_data;
                        good         <= 1'b1;
                        state        <= st_write;
                    end
                st_write:
                    if (!bw.wr_req && !bw.wr_ack)
                        bw.wr_req <= 1'b1;
                    else if (bw.wr_req && bw.wr_ack)
                    begin
                        bw.wr_req <= 1'b0;
                        if (phase_end)
                        begin
                            loop_cnt <= '0;
                            phase    <= (phase == ph_boot) ? ph_map : ph_data;
                        end
                        else if (good)
                            loop_cnt <= loop_cnt + 12'd1;
                        if (phase_end && (phase == ph_map || phase == ph_data))
                            state <= st_done;
                        else if (phase == ph_boot || phase == ph_map)
                            state <= st_fetch;
                        else
                            state <= st_map_rd;
                    end
                st_map_rd:
                    state <= st_map_wait;
                st_map_wait:
                    if (!lm.rd_bit)
                    begin
                        bw.wr_data   <= 1'b0;       // bad loop, no flash bit used
                        bw.fifo_copy <= 1'b0;
                        good         <= 1'b0;
                        state        <= st_write;
                    end
                    else if (phase == ph_head)
                    begin
                        bw.wr_data   <= 1'b1;
                        bw.fifo_copy <= 1'b0;
                        good         <= 1'b1;
                        state        <= st_write;
                    end
                    else
                        state <= st_fetch;
                st_done:
                begin
                    fr.session <= 1'b0;
                    finished   <= 1'b1;
                    state      <= st_idle;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

endmodule

// File: logic/loader_ifs.sv
`timescale 1ns/1ns

interface flash_read_if;
    logic        session;       // held high for the whole flash access
    logic [23:0] flash_addr;
    logic        bit_req;
    logic        bit_ack;
    logic        bit_data;
    logic        cmd_done;      // one cycle after the address is out

    modport master (output session, flash_addr, bit_req, input bit_ack, bit_data, cmd_done);
    modport slave  (input session, flash_addr, bit_req, output bit_ack, bit_data, cmd_done);
endinterface

interface buffer_write_if;
    logic region_start;         // reloads both address counters
    logic region_page;          // page region instead of bootloader region
    logic wr_req;
    logic wr_ack;
    logic wr_data;
    logic fifo_copy;            // also write this bit to the fifo

    modport master (output region_start, region_page, wr_req, wr_data, fifo_copy,
                    input wr_ack);
    modport slave  (input region_start, region_page, wr_req, wr_data, fifo_copy,
                    output wr_ack);
endinterface

interface loop_map_if;
    logic clear;
    logic wr;
    logic rd;
    logic wr_bit;
    logic rd_bit;               // valid the cycle after rd

    modport master (output clear, wr, rd, wr_bit, input rd_bit);
    modport slave  (input clear, wr, rd, wr_bit, output rd_bit);
endinterface

// File: logic/loader_pkg.sv
package loader_pkg;

    localparam int pos_w       = 12;    // loop positions and flash pages
    localparam int out_addr_w  = 15;    // bubble output buffer, 32k x 1
    localparam int fifo_addr_w = 13;    // fifo buffer, 8k x 1

    // serial NOR single-bit read instruction
    localparam logic [7:0] flash_read_cmd = 8'h03;

    localparam logic [pos_w-1:0] boot_page = 12'h805;    // bootloader image page

    // bootloader data starts at 0, page data here
    localparam logic [out_addr_w-1:0] page_data_base = 15'd14336;

endpackage

// File: logic/loop_map_table.sv
`timescale 1ns/1ns

module loop_map_table
(
    input  logic       MCLK,
    input  logic       reset,
    loop_map_if.slave  lm
);

    logic        map_mem [4096];
    logic [11:0] map_idx;

    always_ff @(posedge MCLK)
    begin
        if (reset)
            map_idx <= '0;
        else if (lm.clear)
            map_idx <= '0;
        else if (lm.wr || lm.rd)
            map_idx <= map_idx + 12'd1;
    end

    // the controller stores the map nibble by nibble in reverse bit order
    always_ff @(posedge MCLK)
    begin
        if (lm.wr)
            map_mem[{map_idx[11:4], ~map_idx[3:0]}] <= lm.wr_bit;
        if (lm.rd)
            lm.rd_bit <= map_mem[map_idx];      // linear readback
    end

endmodule

// File: logic/position_page_converter.sv
`timescale 1ns/1ns

module position_page_converter
#(
    parameter int PAGE_COUNT = 2053
)
(
    input  logic                         MCLK,
    input  logic                         reset,
    input  logic                         convert,
    input  logic [loader_pkg::pos_w-1:0] position,
    output logic [loader_pkg::pos_w-1:0] page,
    output logic                         done
);

    import loader_pkg::*;

    logic [pos_w-1:0] value;
    logic             running;

    assign page = value;

    // the emulator reports the position one loop early
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            value   <= '0;
            running <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (convert)
            begin
                value   <= position + 1'b1;
                running <= 1'b1;
            end
            else if (running)
            begin
                if (value >= pos_w'(PAGE_COUNT))
                    value <= value - pos_w'(PAGE_COUNT);   // one wrap per cycle
                else
                begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/spi_flash_reader.sv
`timescale 1ns/1ns

module spi_flash_reader
(
    input  logic         MCLK,
    input  logic         reset,
    flash_read_if.slave  fr,
    output logic         flash_cs_n,
    output logic         flash_sck,
    output logic         flash_mosi,
    input  logic         flash_miso
);

    import loader_pkg::*;

    typedef enum logic [2:0]
    {
        st_idle,
        st_cmd_low,
        st_cmd_high,
        st_cmd_end,
        st_ready,
        st_bit_high,
        st_bit_wait
    } state_t;

    state_t      state;
    logic [31:0] shifter;       // instruction then 24-bit address
    logic [4:0]  bit_cnt;

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            state       <= st_idle;
            flash_cs_n  <= 1'b1;
            flash_sck   <= 1'b0;
            flash_mosi  <= 1'b0;
            fr.cmd_done <= 1'b0;
            fr.bit_ack  <= 1'b0;
        end
        else
        begin
            fr.cmd_done <= 1'b0;
            case (state)
                st_idle:
                    if (fr.session)
                    begin
                        shifter    <= {flash_read_cmd, fr.flash_addr};
                        bit_cnt    <= '0;
                        flash_cs_n <= 1'b0;
                        state      <= st_cmd_low;
                    end
                st_cmd_low:
                begin
                    flash_sck  <= 1'b0;
                    flash_mosi <= shifter[31];      // msb first
                    shifter    <= {shifter[30:0], 1'b0};
                    state      <= st_cmd_high;
                end
                st_cmd_high:
                begin
                    flash_sck <= 1'b1;
                    bit_cnt   <= bit_cnt + 5'd1;
                    state     <= (bit_cnt == 5'd31) ? st_cmd_end : st_cmd_low;
                end
                st_cmd_end:
                begin
                    flash_sck   <= 1'b0;            // flash drives first data bit here
                    flash_mosi  <= 1'b0;
                    fr.cmd_done <= 1'b1;
                    state       <= st_ready;
                end
                st_ready:
                    if (!fr.session)
                    begin
                        flash_cs_n <= 1'b1;
                        state      <= st_idle;
                    end
                    else if (fr.bit_req)
                    begin
                        flash_sck   <= 1'b1;
                        fr.bit_data <= flash_miso;  // sampled on the rising edge
                        state       <= st_bit_high;
                    end
                st_bit_high:
                begin
                    flash_sck  <= 1'b0;
                    fr.bit_ack <= 1'b1;
                    state      <= st_bit_wait;
                end
                st_bit_wait:
                    if (!fr.bit_req)
                    begin
                        fr.bit_ack <= 1'b0;
                        state      <= st_ready;
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

endmodule

// File: tb/bubble_loader_properties.sv
`timescale 1ns/1ns

module bubble_loader_properties
(
    input logic MCLK,
    input logic reset,
    input logic access_req,
    input logic access_ack,
    input logic flash_cs_n,
    input logic flash_sck
);

    int fail_count = 0;

    // idle outputs once reset has been seen
    reset_idle: assert property (@(posedge MCLK) reset |=> !access_ack && flash_cs_n)
    else
    begin
        $error("access_ack or flash_cs_n not idle after reset");
        fail_count++;
    end

    // the emulator may let go of req as soon as it sees ack
    ack_needs_req: assert property (@(posedge MCLK) disable iff (reset)
        $rose(access_ack) |-> $past(access_req))
    else
    begin
        $error("access_ack rose without access_req");
        fail_count++;
    end

    // ack is held for as long as the emulator keeps its request up
    ack_held: assert property (@(posedge MCLK) disable iff (reset)
        access_ack && access_req |=> access_ack)
    else
    begin
        $error("access_ack dropped while access_req was still high");
        fail_count++;
    end

    sck_in_select: assert property (@(posedge MCLK) disable iff (reset)
        $changed(flash_sck) |-> !flash_cs_n)
    else
    begin
        $error("flash_sck toggled with flash_cs_n high");
        fail_count++;
    end

endmodule

// File: tb/flash_model.sv
`timescale 1ns/1ns

module flash_model
#(
    parameter logic [11:0] BOOT_PAGE  = 12'h805,
    parameter int          MAP_START  = 40,     // first map bit inside the boot page
    parameter int          MAP_FORCED = 30
)
(
    input  logic        cs_n,
    input  logic        sck,
    input  logic        mosi,
    output logic        miso,
    output logic [7:0]  cmd,         // last decoded instruction
    output logic [23:0] addr         // last decoded start address
);

    // one image window, 4096 pages of 128 bytes, image bits are not decoded
    logic [7:0]  mem [0:(1<<19)-1];
    logic [31:0] shift_in;
    logic [21:0] rd_ptr;            // bit pointer, msb first inside each byte
    int          bit_cnt;
    int          seed;
    int          b;

    initial
    begin
        miso    = 1'b0;
        cmd     = '0;
        addr    = '0;
        bit_cnt = 0;
        seed    = 32'h249f_5660;
        for (int i = 0; i < (1 << 19); i++)
            mem[i] = $random(seed);
        // every second map bit set, so a page walk always finds enough good loops
        for (int j = 0; j < MAP_FORCED; j++)
        begin
            b = (int'(BOOT_PAGE) << 10) + MAP_START + 2 * j;
            mem[b >> 3][7 - (b & 7)] = 1'b1;
        end
    end

    always @(posedge sck)
    begin
        if (!cs_n && bit_cnt < 32)
        begin
            shift_in = {shift_in[30:0], mosi};
            bit_cnt  = bit_cnt + 1;
            if (bit_cnt == 32)
            begin
                cmd    = shift_in[31:24];
                addr   = shift_in[23:0];
                rd_ptr = {shift_in[18:0], 3'b000};
            end
        end
    end

    // data shifts out on the falling edge, first bit right after the address
    always @(negedge sck)
    begin
        if (!cs_n && bit_cnt == 32)
        begin
            miso   = mem[rd_ptr[21:3]][3'd7 - rd_ptr[2:0]];
            rd_ptr = rd_ptr + 22'd1;
        end
    end

    always @(posedge cs_n)
        bit_cnt = 0;    // new command on the next select

endmodule

// File: tb/tb_bubble_loader.sv
`timescale 1ns/1ns

module tb_bubble_loader;

    import loader_pkg::*;

    localparam int          page_count    = 20;
    localparam int          boot_bits     = 40;
    localparam int          map_bits      = 64;
    localparam int          head_bits     = 6;
    localparam int          page_bits     = 24;
    localparam logic [2:0]  image         = 3'd5;
    localparam logic [11:0] boot_page_ref = 12'h805;
    localparam int          page_base_ref = 14336;
    localparam int          cycle_limit   = 4 * (32 + 64 + 40 + 30) * 6 * 3;   // three accesses

    logic                   MCLK;
    logic                   reset;
    logic [2:0]             image_sel;
    logic                   access_req;
    logic                   access_page;
    logic [pos_w-1:0]       abs_pos;
    logic                   access_ack;
    logic [pos_w-1:0]       curr_page;
    logic                   out_wr_en;
    logic [out_addr_w-1:0]  out_wr_addr;
    logic                   out_wr_data;
    logic                   fifo_wr_en;
    logic [fifo_addr_w-1:0] fifo_wr_addr;
    logic                   fifo_wr_data;
    logic                   flash_cs_n;
    logic                   flash_sck;
    logic                   flash_mosi;
    logic                   flash_miso;
    logic [7:0]             flash_cmd;
    logic [23:0]            flash_addr;

    int   out_addr_q[$];
    logic out_data_q[$];
    int   fifo_addr_q[$];
    logic fifo_data_q[$];
    logic exp_out_q[$];
    logic exp_fifo_q[$];
    logic map_ref [map_bits];       // map bits in flash order

    int checks       = 0;
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;
    int prop_fails;

    bubble_loader_top
    #(
        .PAGE_COUNT (page_count),
        .BOOT_BITS  (boot_bits),
        .MAP_BITS   (map_bits),
        .HEAD_BITS  (head_bits),
        .PAGE_BITS  (page_bits)
    ) DUT
    (
        .MCLK         (MCLK),
        .reset        (reset),
        .image_sel    (image_sel),
        .access_req   (access_req),
        .access_page  (access_page),
        .abs_pos      (abs_pos),
        .access_ack   (access_ack),
        .curr_page    (curr_page),
        .out_wr_en    (out_wr_en),
        .out_wr_addr  (out_wr_addr),
        .out_wr_data  (out_wr_data),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_addr (fifo_wr_addr),
        .fifo_wr_data (fifo_wr_data),
        .flash_cs_n   (flash_cs_n),
        .flash_sck    (flash_sck),
        .flash_mosi   (flash_mosi),
        .flash_miso   (flash_miso)
    );

    flash_model #(.BOOT_PAGE(boot_page_ref), .MAP_START(boot_bits)) serial_flash
    (
        .cs_n (flash_cs_n),
        .sck  (flash_sck),
        .mosi (flash_mosi),
        .miso (flash_miso),
        .cmd  (flash_cmd),
        .addr (flash_addr)
    );

    bind access_request_port bubble_loader_properties hs_props
    (
        .MCLK       (MCLK),
        .reset      (reset),
        .access_req (access_req),
        .access_ack (access_ack),
        .flash_cs_n (1'b1),
        .flash_sck  (1'b0)
    );

    bind spi_flash_reader bubble_loader_properties pin_props
    (
        .MCLK       (MCLK),
        .reset      (reset),
        .access_req (1'b0),
        .access_ack (1'b0),
        .flash_cs_n (flash_cs_n),
        .flash_sck  (flash_sck)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #5 MCLK = ~MCLK;
    end

    always @(posedge MCLK)
    begin
        cycles++;
        if (cycles == cycle_limit)
        begin
            $display("timeout: accesses not finished after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // strobes are one cycle wide, mid-cycle sampling sees each once
    always @(negedge MCLK)
    begin
        if (out_wr_en)
        begin
            out_addr_q.push_back(int'(out_wr_addr));
            out_data_q.push_back(out_wr_data);
        end
        if (fifo_wr_en)
        begin
            fifo_addr_q.push_back(int'(fifo_wr_addr));
            fifo_data_q.push_back(fifo_wr_data);
        end
    end

    function automatic logic flash_bit(input logic [11:0] page, input int k);
        int b;
        b = (int'(page) << 10) + k;     // 128-byte pages, msb first
        return serial_flash.mem[b >> 3][7 - (b & 7)];
    endfunction

    // table entry i holds map bit j, i being j with its low nibble inverted
    function automatic logic map_entry(input int i);
        return map_ref[i ^ 15];
    endfunction

    task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic run_access(input logic page_req, input logic [pos_w-1:0] pos);
        @(negedge MCLK);
        out_addr_q.delete();
        out_data_q.delete();
        fifo_addr_q.delete();
        fifo_data_q.delete();
        access_page = page_req;
        abs_pos     = pos;
        access_req  = 1'b1;
        while (!access_ack)
            @(negedge MCLK);
        repeat (3) @(negedge MCLK);     // emulator keeps its request up a little longer
        access_req = 1'b0;
        while (access_ack)
            @(negedge MCLK);
    endtask

    task automatic compare_writes(input logic fifo_side, input int base, input string name);
        int got_count;
        int want_count;
        got_count  = fifo_side ? fifo_addr_q.size() : out_addr_q.size();
        want_count = fifo_side ? exp_fifo_q.size() : exp_out_q.size();
        expect_value(got_count, want_count, {name, " write count"});
        for (int n = 0; n < want_count && n < got_count; n++)
        begin
            if (fifo_side)
            begin
                expect_value(fifo_addr_q[n], base + n, $sformatf("%s address %0d", name, n));
                expect_value(fifo_data_q[n], exp_fifo_q[n], $sformatf("%s bit %0d", name, n));
            end
            else
            begin
                expect_value(out_addr_q[n], base + n, $sformatf("%s address %0d", name, n));
                expect_value(out_data_q[n], exp_out_q[n], $sformatf("%s bit %0d", name, n));
            end
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors == err0)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", tests_run, name, errors - err0);
        end
    endtask

    task automatic boot_test;
        int err0;
        err0 = errors;
        run_access(1'b0, '0);
        expect_value(flash_cmd, 8'h03, "boot command");
        expect_value(flash_addr, {2'b00, image, boot_page_ref, 7'd0}, "boot address");
        exp_out_q.delete();
        for (int k = 0; k < boot_bits + map_bits; k++)
            exp_out_q.push_back(flash_bit(boot_page_ref, k));
        exp_fifo_q = exp_out_q;         // same bits, same order
        for (int j = 0; j < map_bits; j++)
            map_ref[j] = flash_bit(boot_page_ref, boot_bits + j);
        compare_writes(1'b0, 0, "boot output");
        compare_writes(1'b1, 0, "boot fifo");
        finish_test("bootloader load", err0);
    endtask

    task automatic page_test(input logic [pos_w-1:0] pos, input string name);
        int               err0;
        int               idx;
        int               good;
        int               k;
        logic [pos_w-1:0] want_page;
        logic             e;
        err0      = errors;
        want_page = pos_w'((int'(pos) + 1) % page_count);
        run_access(1'b1, pos);
        expect_value(curr_page, want_page, "converted page");
        expect_value(flash_cmd, 8'h03, "page command");
        expect_value(flash_addr, {2'b00, image, want_page, 7'd0}, "page address");
        exp_out_q.delete();
        exp_fifo_q.delete();
        idx  = 0;
        good = 0;
        while (good < head_bits && idx < map_bits)     // head marks, output only
        begin
            e = map_entry(idx);
            idx++;
            exp_out_q.push_back(e);
            if (e)
                good++;
        end
        good = 0;
        k    = 0;
        while (good < page_bits && idx < map_bits)
        begin
            e = map_entry(idx);
            idx++;
            if (e)
            begin
                exp_out_q.push_back(flash_bit(want_page, k));
                exp_fifo_q.push_back(flash_bit(want_page, k));
                k++;
                good++;
            end
            else
                exp_out_q.push_back(1'b0);  // bad loop
        end
        expect_value(good, page_bits, "good loops found in the map");
        compare_writes(1'b0, page_base_ref, "page output");
        compare_writes(1'b1, 0, "page fifo");
        finish_test(name, err0);
    endtask

    initial
    begin
        reset       = 1'b1;
        image_sel   = image;
        access_req  = 1'b0;
        access_page = 1'b0;
        abs_pos     = '0;
        repeat (2) @(negedge MCLK);
        reset = 1'b0;

        boot_test();
        page_test(12'd5, "page read at position 5");
        page_test(12'd19, "page read at position 19, wrapping");

        prop_fails = DUT.u_port.hs_props.fail_count + DUT.u_flash.pin_props.fail_count;
        if (prop_fails != 0)
        begin
            errors += prop_fails;
            $display("handshake or flash pin assertions failed %0d times", prop_fails);
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
